// ==== Bender.yml ====
package:
  name: energy_monitor

export_include_dirs:
  - .

sources:
  - files:
      - em_pkg.sv
      - em_ctrl.sv
      - em_spin_select.sv
      - em_partial_energy.sv
      - em_accumulator.sv
      - energy_monitor.sv
  - target: simulation
    files:
      - tb_energy_monitor.sv

// ==== em_accumulator.sv ====
/* Energy accumulator */
`timescale 1ns/1ps
`include "em_macros.svh"
`default_nettype none

module em_accumulator import em_pkg::*; (
    input  logic          clk_i,
    input  logic          arst_n_i,
    input  logic          en_i,
    input  logic          flush_i,
    input  logic          weight_take_i,
    input  logic          energy_take_i,
    input  local_energy_t local_energy_i [`EM_PARALLELISM],
    output energy_t       energy_o
);

    energy_acc_t beat_sum;
    energy_acc_t acc_q;
    energy_acc_t acc_half;
    energy_acc_t acc_neg;

    // adder over the parallel units of one beat
    always_comb begin
        beat_sum = '0;
        for (int k = 0; k < `EM_PARALLELISM; k++) begin
            beat_sum = beat_sum + local_energy_i[k];
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            acc_q <= '0;
        end else if (en_i) begin
            if (flush_i || energy_take_i) begin
                acc_q <= '0;
            end else if (weight_take_i) begin
                acc_q <= acc_q + beat_sum;
            end
        end
    end

    // halve toward zero, so add one before the shift when negative
    assign acc_half = (acc_q + energy_acc_t'(acc_q[`EM_ENERGY_BIT])) >>> 1;
    assign acc_neg  = -acc_half;
    assign energy_o = acc_neg[`EM_ENERGY_BIT-1:0];

endmodule

`default_nettype wire

// ==== em_ctrl.sv ====
/* Energy monitor control FSM */
`timescale 1ns/1ps
`default_nettype none

module em_ctrl import em_pkg::*; (
    input  logic clk_i,
    input  logic arst_n_i,
    input  logic en_i,
    input  logic flush_i,
    input  logic config_valid_i,
    input  logic spin_valid_i,
    input  logic weight_valid_i,
    input  logic energy_ready_i,
    input  logic last_beat_i,
    output logic config_ready_o,
    output logic spin_ready_o,
    output logic weight_ready_o,
    output logic energy_valid_o,
    output logic busy_o,
    output logic spin_take_o,
    output logic weight_take_o,
    output logic energy_take_o
);

    em_state_e state_q;
    em_state_e state_d;

    // all handshakes close while disabled
    assign config_ready_o = en_i && (state_q == IDLE);
    assign spin_ready_o   = en_i && (state_q == IDLE);
    assign weight_ready_o = en_i && (state_q == SWEEP);
    assign energy_valid_o = en_i && (state_q == OUTPUT);
    assign busy_o         = (state_q != IDLE);

    assign spin_take_o   = spin_valid_i && spin_ready_o;
    assign weight_take_o = weight_valid_i && weight_ready_o;
    assign energy_take_o = energy_valid_o && energy_ready_i;

    always_comb begin
        state_d = state_q;
        if (flush_i) begin
            state_d = IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (spin_take_o) begin
                        state_d = SWEEP;
                    end
                end
                SWEEP: begin
                    // the beat at the last index closes the sweep
                    if (weight_take_o && last_beat_i) begin
                        state_d = OUTPUT;
                    end
                end
                OUTPUT: begin
                    if (energy_take_o) begin
                        state_d = IDLE;
                    end
                end
                default: state_d = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else if (en_i) begin
            state_q <= state_d;
        end
    end

    // a presented energy is only withdrawn by acceptance, flush or disable
    a_energy_held: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        energy_valid_o && !energy_ready_i && !flush_i |=> energy_valid_o || !en_i
    );

    // a pending config request is held by the upstream side
    a_config_held: assert property (
        @(posedge clk_i) disable iff (!arst_n_i || flush_i)
        config_valid_i && !config_ready_o |=> config_valid_i
    );

endmodule

`default_nettype wire

// ==== em_macros.svh ====
/* Energy monitor size macros */
`ifndef EM_MACROS_SVH
`define EM_MACROS_SVH

// number of spins in one vector
`define EM_NUM_SPIN 16

// spins handled per weight beat, must divide EM_NUM_SPIN
`define EM_PARALLELISM 2

// signed coupling and bias widths
`define EM_BITJ 4
`define EM_BITH 4

// unsigned bias scaling width
`define EM_SCALING_BIT 4

// result widths
`define EM_LOCAL_ENERGY_BIT 16
`define EM_ENERGY_BIT 32

`endif

// ==== em_partial_energy.sv ====
/* Local energy of one spin */
`timescale 1ns/1ps
`include "em_macros.svh"
`default_nettype none

module em_partial_energy import em_pkg::*; (
    input  spin_vec_t     spin_vector_i,
    input  logic          current_spin_i,
    input  weight_row_t   weight_row_i,
    input  hbias_t        hbias_i,
    input  hscale_t       hscaling_i,
    output local_energy_t energy_o
);

    local_energy_t field_sum;
    local_energy_t bias_term;
    local_energy_t raw_energy;

    // coupling field, a spin bit of 0 flips the sign of its coupling
    always_comb begin
        logic signed [`EM_BITJ-1:0] coupling;
        field_sum = '0;
        coupling  = '0;
        for (int j = 0; j < `EM_NUM_SPIN; j++) begin
            coupling = weight_row_i[j*`EM_BITJ +: `EM_BITJ];
            if (spin_vector_i[j]) begin
                field_sum = field_sum + coupling;
            end else begin
                field_sum = field_sum - coupling;
            end
        end
    end

    // scaling is unsigned, widen it with a zero before the signed product
    assign bias_term = hbias_i * $signed({1'b0, hscaling_i});

    // bias counts twice to match the doubled coupling sum
    assign raw_energy = field_sum + (bias_term <<< 1);

    assign energy_o = current_spin_i ? raw_energy : -raw_energy;

endmodule

`default_nettype wire

// ==== em_pkg.sv ====
/* Energy monitor types */
`include "em_macros.svh"
`default_nettype none

package em_pkg;

    // spin vector and indexing
    typedef logic [`EM_NUM_SPIN-1:0] spin_vec_t;
    typedef logic [$clog2(`EM_NUM_SPIN)-1:0] spin_idx_t;
    typedef logic [`EM_PARALLELISM-1:0] spin_par_t;

    // couplings, one row per spin, row k of a beat at slice k
    typedef logic [`EM_NUM_SPIN*`EM_BITJ-1:0] weight_row_t;
    typedef logic [`EM_PARALLELISM*`EM_NUM_SPIN*`EM_BITJ-1:0] weight_bus_t;

    // bias and its scaling
    typedef logic signed [`EM_BITH-1:0] hbias_t;
    typedef logic [`EM_PARALLELISM*`EM_BITH-1:0] hbias_bus_t;
    typedef logic [`EM_SCALING_BIT-1:0] hscale_t;
    typedef logic [`EM_PARALLELISM*`EM_SCALING_BIT-1:0] hscale_bus_t;

    // energies
    typedef logic signed [`EM_LOCAL_ENERGY_BIT-1:0] local_energy_t;
    typedef logic signed [`EM_ENERGY_BIT-1:0] energy_t;
    // one extra bit, the sum counts every pair twice
    typedef logic signed [`EM_ENERGY_BIT:0] energy_acc_t;

    typedef enum logic [1:0] {
        IDLE,
        SWEEP,
        OUTPUT
    } em_state_e;

endpackage

`default_nettype wire

// ==== em_spin_select.sv ====
/* Spin cache and index counter */
`timescale 1ns/1ps
`include "em_macros.svh"
`default_nettype none

module em_spin_select import em_pkg::*; (
    input  logic      clk_i,
    input  logic      arst_n_i,
    input  logic      en_i,
    input  logic      flush_i,
    input  logic      config_take_i,
    input  spin_idx_t config_counter_i,
    input  logic      spin_take_i,
    input  spin_vec_t spin_i,
    input  logic      weight_take_i,
    output spin_vec_t spin_o,
    output spin_idx_t counter_spin_o,
    output spin_par_t current_spin_o,
    output logic      last_beat_o
);

    localparam spin_idx_t LastIdx = spin_idx_t'(`EM_NUM_SPIN - `EM_PARALLELISM);
    localparam spin_idx_t StepIdx = spin_idx_t'(`EM_PARALLELISM);

    spin_idx_t start_q;
    spin_idx_t counter_q;
    spin_vec_t spin_q;

    // start index survives flush
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            start_q <= '0;
        end else if (en_i && config_take_i) begin
            start_q <= config_counter_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (en_i && spin_take_i) begin
            spin_q <= spin_i;
        end
    end

    // a config arriving with the spin vector takes effect at once
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            counter_q <= '0;
        end else if (en_i) begin
            if (flush_i) begin
                counter_q <= '0;
            end else if (spin_take_i) begin
                counter_q <= config_take_i ? config_counter_i : start_q;
            end else if (weight_take_i) begin
                counter_q <= counter_q + StepIdx;
            end
        end
    end

    // little-endian, bit k of the beat is spin counter+k
    assign current_spin_o = spin_q[counter_q +: `EM_PARALLELISM];
    assign last_beat_o    = (counter_q == LastIdx);
    assign spin_o         = spin_q;
    assign counter_spin_o = counter_q;

    a_start_aligned: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        (start_q % `EM_PARALLELISM) == 0
    );

    // after the last beat no weight may enter before the next spin vector
    a_no_overrun: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        weight_take_i && last_beat_o |=> (!weight_take_i until spin_take_i)
    );

endmodule

`default_nettype wire

// ==== energy_monitor.sv ====
/* Ising energy monitor */
`timescale 1ns/1ps
`include "em_macros.svh"
`default_nettype none

module energy_monitor import em_pkg::*; (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic        en_i,
    input  logic        flush_i,
    input  logic        config_valid_i,
    input  spin_idx_t   config_counter_i,
    output logic        config_ready_o,
    input  logic        spin_valid_i,
    input  spin_vec_t   spin_i,
    output logic        spin_ready_o,
    input  logic        weight_valid_i,
    input  weight_bus_t weight_i,
    input  hbias_bus_t  hbias_i,
    input  hscale_bus_t hscaling_i,
    output logic        weight_ready_o,
    output spin_idx_t   counter_spin_o,
    output logic        energy_valid_o,
    input  logic        energy_ready_i,
    output energy_t     energy_o,
    output spin_vec_t   spin_o,
    output logic        busy_o
);

    logic          config_take;
    logic          spin_take;
    logic          weight_take;
    logic          energy_take;
    logic          last_beat;
    spin_par_t     current_spin;
    local_energy_t local_energy [`EM_PARALLELISM];

    assign config_take = config_valid_i && config_ready_o;

    em_ctrl u_em_ctrl (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .en_i           (en_i),
        .flush_i        (flush_i),
        .config_valid_i (config_valid_i),
        .spin_valid_i   (spin_valid_i),
        .weight_valid_i (weight_valid_i),
        .energy_ready_i (energy_ready_i),
        .last_beat_i    (last_beat),
        .config_ready_o (config_ready_o),
        .spin_ready_o   (spin_ready_o),
        .weight_ready_o (weight_ready_o),
        .energy_valid_o (energy_valid_o),
        .busy_o         (busy_o),
        .spin_take_o    (spin_take),
        .weight_take_o  (weight_take),
        .energy_take_o  (energy_take)
    );

    em_spin_select u_em_spin_select (
        .clk_i            (clk_i),
        .arst_n_i         (arst_n_i),
        .en_i             (en_i),
        .flush_i          (flush_i),
        .config_take_i    (config_take),
        .config_counter_i (config_counter_i),
        .spin_take_i      (spin_take),
        .spin_i           (spin_i),
        .weight_take_i    (weight_take),
        .spin_o           (spin_o),
        .counter_spin_o   (counter_spin_o),
        .current_spin_o   (current_spin),
        .last_beat_o      (last_beat)
    );

    // one unit per spin of the beat, unit k takes slice k of each bus
    for (genvar k = 0; k < `EM_PARALLELISM; k++) begin : gen_unit
        em_partial_energy u_em_partial_energy (
            .spin_vector_i  (spin_o),
            .current_spin_i (current_spin[k]),
            .weight_row_i   (weight_i[k*$bits(weight_row_t) +: $bits(weight_row_t)]),
            .hbias_i        (hbias_i[k*`EM_BITH +: `EM_BITH]),
            .hscaling_i     (hscaling_i[k*`EM_SCALING_BIT +: `EM_SCALING_BIT]),
            .energy_o       (local_energy[k])
        );
    end

    em_accumulator u_em_accumulator (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .en_i           (en_i),
        .flush_i        (flush_i),
        .weight_take_i  (weight_take),
        .energy_take_i  (energy_take),
        .local_energy_i (local_energy),
        .energy_o       (energy_o)
    );

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
em_pkg.sv
em_ctrl.sv
em_spin_select.sv
em_partial_energy.sv
em_accumulator.sv
energy_monitor.sv
tb_energy_monitor.sv

// ==== tb_energy_monitor.sv ====
/* Energy monitor testbench */
`timescale 1ns/1ps
`include "em_macros.svh"
`default_nettype none

module tb_energy_monitor;
    import em_pkg::*;

    localparam int TimeoutCycles = 200;

    logic        clk_i;
    logic        arst_n_i;
    logic        en_i;
    logic        flush_i;
    logic        config_valid_i;
    spin_idx_t   config_counter_i;
    logic        config_ready_o;
    logic        spin_valid_i;
    spin_vec_t   spin_i;
    logic        spin_ready_o;
    logic        weight_valid_i;
    weight_bus_t weight_i;
    hbias_bus_t  hbias_i;
    hscale_bus_t hscaling_i;
    logic        weight_ready_o;
    spin_idx_t   counter_spin_o;
    logic        energy_valid_o;
    logic        energy_ready_i;
    energy_t     energy_o;
    spin_vec_t   spin_o;
    logic        busy_o;

    integer seed;

    // data of the job in flight
    spin_vec_t   job_spins;
    spin_idx_t   job_start;
    int          job_beats;
    weight_row_t job_rows [`EM_NUM_SPIN];
    hbias_t      job_hb [`EM_NUM_SPIN];
    hscale_t     job_hs [`EM_NUM_SPIN];

    energy_monitor u_energy_monitor (.*);

    initial clk_i = 1'b0;
    always #20 clk_i = ~clk_i;

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic energy_is(input string name, input energy_t exp, input energy_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic spins_are(input string name, input spin_vec_t exp, input spin_vec_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic index_is(input string name, input spin_idx_t exp, input spin_idx_t act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic level_is(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            abort_run();
        end
    endtask

    // energy straight from the spin rule where bit 1 is +1 and bit 0 is -1
    function automatic energy_t model_energy();
        int sum;
        int field;
        int jij;
        sum = 0;
        for (int i = job_start; i < `EM_NUM_SPIN; i++) begin
            field = 0;
            for (int j = 0; j < `EM_NUM_SPIN; j++) begin
                jij = $signed(job_rows[i][j*`EM_BITJ +: `EM_BITJ]);
                field += job_spins[j] ? jij : -jij;
            end
            field += 2 * int'(job_hb[i]) * int'(job_hs[i]);
            sum += job_spins[i] ? field : -field;
        end
        return energy_t'(-(sum / 2));
    endfunction

    task automatic make_job(input spin_idx_t start);
        job_start = start;
        job_beats = (`EM_NUM_SPIN - start) / `EM_PARALLELISM;
        job_spins = spin_vec_t'($random(seed));
        for (int i = 0; i < `EM_NUM_SPIN; i++) begin
            job_rows[i] = {$random(seed), $random(seed)};
            job_hb[i] = hbias_t'($random(seed));
            job_hs[i] = hscale_t'($random(seed));
        end
    endtask

    task automatic push_config(input spin_idx_t start);
        int waited;
        waited = 0;
        @(posedge clk_i);
        config_valid_i   <= 1'b1;
        config_counter_i <= start;
        @(negedge clk_i);
        while (!config_ready_o) begin
            waited++;
            if (waited > TimeoutCycles) begin
                $display("timeout: config_ready_o never went high");
                abort_run();
            end
            @(negedge clk_i);
        end
        @(posedge clk_i);
        config_valid_i <= 1'b0;
    endtask

    // with_cfg sends the start index in the same cycle as the spins
    task automatic load_spins(input logic with_cfg);
        int waited;
        waited = 0;
        @(posedge clk_i);
        spin_valid_i <= 1'b1;
        spin_i       <= job_spins;
        if (with_cfg) begin
            config_valid_i   <= 1'b1;
            config_counter_i <= job_start;
        end
        @(negedge clk_i);
        while (!spin_ready_o) begin
            waited++;
            if (waited > TimeoutCycles) begin
                $display("timeout: spin_ready_o never went high");
                abort_run();
            end
            @(negedge clk_i);
        end
        @(posedge clk_i);
        spin_valid_i   <= 1'b0;
        config_valid_i <= 1'b0;
        @(negedge clk_i);
        index_is("counter_spin_o", job_start, counter_spin_o);
        spins_are("spin_o", job_spins, spin_o);
        level_is("busy_o", 1'b1, busy_o);
        level_is("weight_ready_o", 1'b1, weight_ready_o);
    endtask

    // beats first .. first+count-1 of the job with random idle gaps
    task automatic stream_beats(input int first, input int count);
        int waited;
        int idx;
        for (int b = first; b < first + count; b++) begin
            repeat ($random(seed) & 3) begin
                @(posedge clk_i);
                weight_valid_i <= 1'b0;
            end
            @(posedge clk_i);
            weight_valid_i <= 1'b1;
            for (int k = 0; k < `EM_PARALLELISM; k++) begin
                idx = job_start + b * `EM_PARALLELISM + k;
                weight_i[k*$bits(weight_row_t) +: $bits(weight_row_t)] <= job_rows[idx];
                hbias_i[k*`EM_BITH +: `EM_BITH] <= job_hb[idx];
                hscaling_i[k*`EM_SCALING_BIT +: `EM_SCALING_BIT] <= job_hs[idx];
            end
            waited = 0;
            @(negedge clk_i);
            while (!weight_ready_o) begin
                waited++;
                if (waited > TimeoutCycles) begin
                    $display("timeout: weight_ready_o never went high");
                    abort_run();
                end
                @(negedge clk_i);
            end
            @(posedge clk_i);
            weight_valid_i <= 1'b0;
            @(negedge clk_i);
            level_is("busy_o", 1'b1, busy_o);
            level_is("energy_valid_o", (b == job_beats - 1), energy_valid_o);
        end
    endtask

    // hold keeps energy_ready_i low for that many cycles first
    task automatic collect_energy(input int hold);
        int waited;
        energy_t held;
        waited = 0;
        while (!energy_valid_o) begin
            waited++;
            if (waited > TimeoutCycles) begin
                $display("timeout: energy_valid_o never went high");
                abort_run();
            end
            @(negedge clk_i);
        end
        held = energy_o;
        energy_is("energy_o", model_energy(), energy_o);
        repeat (hold) begin
            @(negedge clk_i);
            level_is("energy_valid_o", 1'b1, energy_valid_o);
            level_is("spin_ready_o", 1'b0, spin_ready_o);
            level_is("busy_o", 1'b1, busy_o);
            energy_is("energy_o", held, energy_o);
        end
        @(posedge clk_i);
        energy_ready_i <= 1'b1;
        @(posedge clk_i);
        energy_ready_i <= 1'b0;
        @(negedge clk_i);
        level_is("energy_valid_o", 1'b0, energy_valid_o);
        level_is("busy_o", 1'b0, busy_o);
        level_is("spin_ready_o", 1'b1, spin_ready_o);
    endtask

    initial begin
        spin_idx_t start;
        spin_idx_t frozen;
        int cut;
        seed             = 32'hd138;
        arst_n_i         = 1'b0;
        en_i             = 1'b1;
        flush_i          = 1'b0;
        config_valid_i   = 1'b0;
        config_counter_i = '0;
        spin_valid_i     = 1'b0;
        spin_i           = '0;
        weight_valid_i   = 1'b0;
        weight_i         = '0;
        hbias_i          = '0;
        hscaling_i       = '0;
        energy_ready_i   = 1'b0;
        repeat (10) @(posedge clk_i);
        arst_n_i <= 1'b1;
        @(negedge clk_i);

        level_is("busy_o", 1'b0, busy_o);
        level_is("weight_ready_o", 1'b0, weight_ready_o);
        level_is("energy_valid_o", 1'b0, energy_valid_o);
        level_is("config_ready_o", 1'b1, config_ready_o);
        level_is("spin_ready_o", 1'b1, spin_ready_o);

        // full sweeps from index 0
        repeat (20) begin
            make_job('0);
            load_spins(1'b0);
            stream_beats(0, job_beats);
            collect_energy(0);
        end

        // partial sweeps where odd jobs send config together with the spins
        for (int n = 0; n < 8; n++) begin
            start = spin_idx_t'(($random(seed) & 7) * 2);
            make_job(start);
            if (n % 2 == 0) begin
                push_config(start);
            end
            load_spins(n % 2 == 1);
            stream_beats(0, job_beats);
            collect_energy(0);
        end

        // energy held back by the consumer
        push_config('0);
        repeat (4) begin
            make_job('0);
            load_spins(1'b0);
            stream_beats(0, job_beats);
            collect_energy(1 + ($random(seed) & 15));
        end

        // flush in the middle of a sweep
        make_job('0);
        load_spins(1'b0);
        cut = 1 + ($random(seed) & 3);
        stream_beats(0, cut);
        @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        @(negedge clk_i);
        level_is("busy_o", 1'b0, busy_o);
        level_is("spin_ready_o", 1'b1, spin_ready_o);
        level_is("weight_ready_o", 1'b0, weight_ready_o);
        index_is("counter_spin_o", '0, counter_spin_o);
        make_job('0);
        load_spins(1'b0);
        stream_beats(0, job_beats);
        collect_energy(0);

        // enable dropped in the middle of a sweep
        make_job('0);
        load_spins(1'b0);
        cut = 2 + ($random(seed) & 3);
        stream_beats(0, cut);
        frozen = counter_spin_o;
        index_is("counter_spin_o", spin_idx_t'(cut * `EM_PARALLELISM), frozen);
        // a pending beat must not enter while disabled
        @(posedge clk_i);
        en_i           <= 1'b0;
        weight_valid_i <= 1'b1;
        repeat (3 + ($random(seed) & 7)) begin
            @(negedge clk_i);
            level_is("config_ready_o", 1'b0, config_ready_o);
            level_is("spin_ready_o", 1'b0, spin_ready_o);
            level_is("weight_ready_o", 1'b0, weight_ready_o);
            level_is("energy_valid_o", 1'b0, energy_valid_o);
            index_is("counter_spin_o", frozen, counter_spin_o);
        end
        @(posedge clk_i);
        en_i           <= 1'b1;
        weight_valid_i <= 1'b0;
        stream_beats(cut, job_beats - cut);
        collect_energy(0);

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
